//--- build.f
+incdir+design
+incdir+verification
design/fabricPkg.sv
design/creditFifo.sv
design/dualPortMem.sv
design/ctrlRegs.sv
design/dataMemNode.sv
design/requestRouter.sv
design/responseCollector.sv
design/memFabricTop.sv
verification/memFabricTb.sv

//--- design/creditFifo.sv
`timescale 1ns/100ps

module creditFifo #(
    parameter type PAYLOAD_T = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     QClk,
    input  logic     arstN,
    input  logic     push,
    input  PAYLOAD_T pushData,
    input  logic     pop,
    output PAYLOAD_T popData,
    output logic     notEmpty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    PAYLOAD_T         slots [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge QClk) begin
        if (push) begin
            slots[wrPtr] <= pushData;
        end
    end

    // Sender holds credits, so push never sees a full buffer
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign popData  = slots[rdPtr];
    assign notEmpty = (count != '0);

endmodule

//--- design/ctrlRegs.sv
`timescale 1ns/100ps
`include "fabric_macros.svh"

module ctrlRegs (
    input  logic                              QClk,
    input  logic                              arstN,
    input  logic [$clog2(`FAB_CR_COUNT)-1:0]  coreOffset,
    input  logic [31:0]                       coreWrData,
    input  logic [3:0]                        coreByteEn,
    input  logic                              coreRdEn,
    input  logic                              coreWrEn,
    input  logic [$clog2(`FAB_CR_COUNT)-1:0]  fabOffset,
    input  logic [31:0]                       fabWrData,
    input  logic                              fabRdEn,
    input  logic                              fabWrEn,
    output logic [31:0]                       coreRdData,
    output logic [31:0]                       fabRdData,
    output fabricPkg::coreCr_t                crOut
);

    fabricPkg::coreCr_t regs;

    // Fabric writes whole words, core bytes land on top
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            regs <= '0;
        end else begin
            if (fabWrEn) begin
                regs[fabOffset] <= fabWrData;
            end
            for (int b = 0; b < 4; b++) begin
                if (coreWrEn && coreByteEn[b]) begin
                    regs[coreOffset][8*b +: 8] <= coreWrData[8*b +: 8];
                end
            end
        end
    end

    // Registered reads, same latency as the memory
    always_ff @(posedge QClk) begin
        if (coreRdEn) begin
            coreRdData <= regs[coreOffset];
        end
        if (fabRdEn) begin
            fabRdData <= regs[fabOffset];
        end
    end

    assign crOut = regs;

endmodule

//--- design/dataMemNode.sv
`timescale 1ns/100ps
`include "fabric_macros.svh"

module dataMemNode #(
    parameter int NODE_ID = 0
) (
    input  logic                   QClk,
    input  logic                   arstN,
    input  fabricPkg::coreReq_t    coreReq,
    input  logic                   reqValid,
    input  fabricPkg::fabricReq_t  req,
    input  logic                   rspPop,
    output logic [31:0]            coreRdData,
    output fabricPkg::coreCr_t     crOut,
    output logic                   credit,
    output logic                   rspValid,
    output fabricPkg::fabricRsp_t  rsp
);

    localparam int CR_IDX_W = $clog2(`FAB_CR_COUNT);
    localparam int MEM_AW   = $clog2(`FAB_MEM_WORDS);
    localparam int CRED_W   = $clog2(`FAB_NODE_RSP_DEPTH + 2);

    logic                  coreMemRd;
    logic                  coreMemWr;
    logic                  coreCrRd;
    logic                  coreCrWr;
    logic                  fabRd;
    logic                  fabWr;
    logic                  fabMemRd;
    logic                  fabMemWr;
    logic                  fabCrRd;
    logic                  fabCrWr;
    logic                  coreMemRdQ;
    logic                  coreCrRdQ;
    logic                  fabMemRdQ;
    logic                  fabCrRdQ;
    logic                  fabWrQ;
    logic [3:0]            tagQ;
    logic [31:0]           memRdDataA;
    logic [31:0]           memRdDataB;
    logic [31:0]           crRdDataCore;
    logic [31:0]           crRdDataFab;
    logic                  rspPush;
    fabricPkg::fabricRsp_t rspIn;
    logic [CRED_W-1:0]     owedCredit;
    logic [CRED_W-1:0]     creditTotal;

    // ==================================================
    // Region decode
    // ==================================================
    assign coreMemRd = coreReq.rdEn && (coreReq.region == fabricPkg::REGION_DMEM);
    assign coreMemWr = coreReq.wrEn && (coreReq.region == fabricPkg::REGION_DMEM);
    assign coreCrRd  = coreReq.rdEn && (coreReq.region == fabricPkg::REGION_CR);
    assign coreCrWr  = coreReq.wrEn && (coreReq.region == fabricPkg::REGION_CR);

    // Node ID was already matched by the router
    assign fabRd    = reqValid && (req.opcode == fabricPkg::OP_RD);
    assign fabWr    = reqValid && (req.opcode == fabricPkg::OP_WR);
    assign fabMemRd = fabRd && (req.addr.region == fabricPkg::REGION_DMEM);
    assign fabMemWr = fabWr && (req.addr.region == fabricPkg::REGION_DMEM);
    assign fabCrRd  = fabRd && (req.addr.region == fabricPkg::REGION_CR);
    assign fabCrWr  = fabWr && (req.addr.region == fabricPkg::REGION_CR);

    // ==================================================
    // Storage
    // ==================================================
    dualPortMem #(.WORDS(`FAB_MEM_WORDS)) dMem (
        .QClk    (QClk),
        .addrA   (coreReq.offset[MEM_AW-1:0]),
        .byteEnA (coreReq.byteEn),
        .wrDataA (coreReq.wrData),
        .rdEnA   (coreMemRd),
        .wrEnA   (coreMemWr),
        .addrB   (req.addr.offset[MEM_AW-1:0]),
        .byteEnB (4'b1111),
        .wrDataB (req.data),
        .rdEnB   (fabMemRd),
        .wrEnB   (fabMemWr),
        .rdDataA (memRdDataA),
        .rdDataB (memRdDataB)
    );

    ctrlRegs crBlock (
        .QClk       (QClk),
        .arstN      (arstN),
        .coreOffset (coreReq.offset[CR_IDX_W-1:0]),
        .coreWrData (coreReq.wrData),
        .coreByteEn (coreReq.byteEn),
        .coreRdEn   (coreCrRd),
        .coreWrEn   (coreCrWr),
        .fabOffset  (req.addr.offset[CR_IDX_W-1:0]),
        .fabWrData  (req.data),
        .fabRdEn    (fabCrRd),
        .fabWrEn    (fabCrWr),
        .coreRdData (crRdDataCore),
        .fabRdData  (crRdDataFab),
        .crOut      (crOut)
    );

    // Read kind follows the data by one cycle
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            coreMemRdQ <= 1'b0;
            coreCrRdQ  <= 1'b0;
            fabMemRdQ  <= 1'b0;
            fabCrRdQ   <= 1'b0;
            fabWrQ     <= 1'b0;
        end else begin
            coreMemRdQ <= coreMemRd;
            coreCrRdQ  <= coreCrRd;
            fabMemRdQ  <= fabMemRd;
            fabCrRdQ   <= fabCrRd;
            fabWrQ     <= fabWr;
        end
    end

    always_ff @(posedge QClk) begin
        if (fabRd) begin
            tagQ <= req.tag;
        end
    end

    assign coreRdData = coreMemRdQ ? memRdDataA   :
                        coreCrRdQ  ? crRdDataCore :
                                     32'b0;

    // ==================================================
    // Response queue and credit return
    // ==================================================
    assign rspPush      = fabMemRdQ || fabCrRdQ;
    assign rspIn.nodeId = 2'(NODE_ID);
    assign rspIn.tag    = tagQ;
    assign rspIn.data   = fabMemRdQ ? memRdDataB : crRdDataFab;

    creditFifo #(
        .PAYLOAD_T (fabricPkg::fabricRsp_t),
        .DEPTH     (`FAB_NODE_RSP_DEPTH)
    ) rspFifo (
        .QClk     (QClk),
        .arstN    (arstN),
        .push     (rspPush),
        .pushData (rspIn),
        .pop      (rspPop),
        .popData  (rsp),
        .notEmpty (rspValid)
    );

    // A write done and a pop can free two slots at once, the spare waits
    assign creditTotal = owedCredit + CRED_W'(fabWrQ) + CRED_W'(rspPop);
    assign credit      = (creditTotal != '0);

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            owedCredit <= '0;
        end else begin
            owedCredit <= creditTotal - CRED_W'(credit);
        end
    end

endmodule

//--- design/dualPortMem.sv
`timescale 1ns/100ps

module dualPortMem #(
    parameter int WORDS = 256
) (
    input  logic                       QClk,
    input  logic [$clog2(WORDS)-1:0]   addrA,
    input  logic [3:0]                 byteEnA,
    input  logic [31:0]                wrDataA,
    input  logic                       rdEnA,
    input  logic                       wrEnA,
    input  logic [$clog2(WORDS)-1:0]   addrB,
    input  logic [3:0]                 byteEnB,
    input  logic [31:0]                wrDataB,
    input  logic                       rdEnB,
    input  logic                       wrEnB,
    output logic [31:0]                rdDataA,
    output logic [31:0]                rdDataB
);

    logic [31:0] mem [WORDS];

    // Contents start cleared
    initial begin
        for (int w = 0; w < WORDS; w++) begin
            mem[w] = '0;
        end
    end

    // Port B lanes go first, port A overwrites them on a shared word
    always_ff @(posedge QClk) begin
        for (int b = 0; b < 4; b++) begin
            if (wrEnB && byteEnB[b]) begin
                mem[addrB][8*b +: 8] <= wrDataB[8*b +: 8];
            end
        end
        for (int b = 0; b < 4; b++) begin
            if (wrEnA && byteEnA[b]) begin
                mem[addrA][8*b +: 8] <= wrDataA[8*b +: 8];
            end
        end
        if (rdEnA) begin
            rdDataA <= mem[addrA];
        end
        if (rdEnB) begin
            rdDataB <= mem[addrB];
        end
    end

endmodule

//--- design/fabricPkg.sv
`include "fabric_macros.svh"

package fabricPkg;

    // Fabric opcodes
    typedef enum logic {
        OP_RD = 1'b0,
        OP_WR = 1'b1
    } opcode_e;

    // Node address regions
    typedef enum logic {
        REGION_DMEM = 1'b0,
        REGION_CR   = 1'b1
    } region_e;

    typedef struct packed {
        logic [1:0] nodeId;
        region_e    region;
        logic [7:0] offset;
    } fabricAddr_t;

    typedef struct packed {
        opcode_e     opcode;
        fabricAddr_t addr;
        logic [31:0] data;
        logic [3:0]  tag;
    } fabricReq_t;

    typedef struct packed {
        logic [1:0]  nodeId;
        logic [3:0]  tag;
        logic [31:0] data;
    } fabricRsp_t;

    // Local core access, one per cycle
    typedef struct packed {
        logic        rdEn;
        logic        wrEn;
        region_e     region;
        logic [7:0]  offset;
        logic [3:0]  byteEn;
        logic [31:0] wrData;
    } coreReq_t;

    typedef logic [`FAB_CR_COUNT-1:0][31:0] coreCr_t;

endpackage

//--- design/fabric_macros.svh
`ifndef FABRIC_MACROS_SVH
`define FABRIC_MACROS_SVH

// ==================================================
// Fabric sizing
// ==================================================

// Nodes on the fabric
`define FAB_NUM_NODES 4

// Words per node memory, and CRs per node
`define FAB_MEM_WORDS 256
`define FAB_CR_COUNT 4

// Queue depths, which also set the credit pools
`define FAB_NODE_RSP_DEPTH 4
`define FAB_REQ_FIFO_DEPTH 4
`define FAB_OUT_CREDITS 2

`endif

//--- design/memFabricTop.sv
`timescale 1ns/100ps
`include "fabric_macros.svh"

module memFabricTop (
    input  logic                                          QClk,
    input  logic                                          arstN,
    input  logic                                          reqValid,
    input  fabricPkg::fabricReq_t                         req,
    input  logic                                          outCredit,
    input  fabricPkg::coreReq_t [`FAB_NUM_NODES-1:0]      coreReq,
    output logic                                          reqCredit,
    output logic                                          outValid,
    output fabricPkg::fabricRsp_t                         outRsp,
    output logic [`FAB_NUM_NODES-1:0][31:0]               coreRdData,
    output fabricPkg::coreCr_t [`FAB_NUM_NODES-1:0]       crOut
);

    logic [`FAB_NUM_NODES-1:0]                    nodeReqValid;
    fabricPkg::fabricReq_t                        nodeReq;
    logic [`FAB_NUM_NODES-1:0]                    nodeCredit;
    logic [`FAB_NUM_NODES-1:0]                    rspValid;
    fabricPkg::fabricRsp_t [`FAB_NUM_NODES-1:0]   rspData;
    logic [`FAB_NUM_NODES-1:0]                    rspPop;

    requestRouter router (
        .QClk         (QClk),
        .arstN        (arstN),
        .reqValid     (reqValid),
        .req          (req),
        .nodeCredit   (nodeCredit),
        .reqCredit    (reqCredit),
        .nodeReqValid (nodeReqValid),
        .nodeReq      (nodeReq)
    );

    // One node per ID, sharing the router request bus
    for (genvar n = 0; n < `FAB_NUM_NODES; n++) begin : gNode
        dataMemNode #(.NODE_ID(n)) node (
            .QClk       (QClk),
            .arstN      (arstN),
            .coreReq    (coreReq[n]),
            .reqValid   (nodeReqValid[n]),
            .req        (nodeReq),
            .rspPop     (rspPop[n]),
            .coreRdData (coreRdData[n]),
            .crOut      (crOut[n]),
            .credit     (nodeCredit[n]),
            .rspValid   (rspValid[n]),
            .rsp        (rspData[n])
        );
    end

    responseCollector collector (
        .QClk      (QClk),
        .arstN     (arstN),
        .rspValid  (rspValid),
        .rspData   (rspData),
        .outCredit (outCredit),
        .rspPop    (rspPop),
        .outValid  (outValid),
        .outRsp    (outRsp)
    );

endmodule

//--- design/requestRouter.sv
`timescale 1ns/100ps
`include "fabric_macros.svh"

module requestRouter (
    input  logic                        QClk,
    input  logic                        arstN,
    input  logic                        reqValid,
    input  fabricPkg::fabricReq_t       req,
    input  logic [`FAB_NUM_NODES-1:0]   nodeCredit,
    output logic                        reqCredit,
    output logic [`FAB_NUM_NODES-1:0]   nodeReqValid,
    output fabricPkg::fabricReq_t       nodeReq
);

    localparam int CNT_W = $clog2(`FAB_NODE_RSP_DEPTH + 1);

    fabricPkg::fabricReq_t       head;
    logic                        headValid;
    logic                        send;
    logic [`FAB_NUM_NODES-1:0]   sendMask;
    logic [CNT_W-1:0]            credits [`FAB_NUM_NODES];

    creditFifo #(
        .PAYLOAD_T (fabricPkg::fabricReq_t),
        .DEPTH     (`FAB_REQ_FIFO_DEPTH)
    ) inFifo (
        .QClk     (QClk),
        .arstN    (arstN),
        .push     (reqValid),
        .pushData (req),
        .pop      (send),
        .popData  (head),
        .notEmpty (headValid)
    );

    // In order, head blocks until its node has room
    assign send      = headValid && (credits[head.addr.nodeId] != '0);
    assign sendMask  = `FAB_NUM_NODES'(send) << head.addr.nodeId;
    assign reqCredit = send;

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            nodeReqValid <= '0;
            for (int i = 0; i < `FAB_NUM_NODES; i++) begin
                credits[i] <= CNT_W'(`FAB_NODE_RSP_DEPTH);
            end
        end else begin
            nodeReqValid <= sendMask;
            for (int i = 0; i < `FAB_NUM_NODES; i++) begin
                credits[i] <= credits[i] + CNT_W'(nodeCredit[i]) - CNT_W'(sendMask[i]);
            end
        end
    end

    always_ff @(posedge QClk) begin
        if (send) begin
            nodeReq <= head;
        end
    end

endmodule

//--- design/responseCollector.sv
`timescale 1ns/100ps
`include "fabric_macros.svh"

module responseCollector (
    input  logic                                          QClk,
    input  logic                                          arstN,
    input  logic [`FAB_NUM_NODES-1:0]                     rspValid,
    input  fabricPkg::fabricRsp_t [`FAB_NUM_NODES-1:0]    rspData,
    input  logic                                          outCredit,
    output logic [`FAB_NUM_NODES-1:0]                     rspPop,
    output logic                                          outValid,
    output fabricPkg::fabricRsp_t                         outRsp
);

    localparam int IDX_W = $clog2(`FAB_NUM_NODES);
    localparam int CNT_W = $clog2(`FAB_OUT_CREDITS + 1);

    logic [IDX_W-1:0] lastGrant;
    logic [IDX_W-1:0] grantIdx;
    logic             found;
    logic             grant;
    logic [CNT_W-1:0] credits;

    // Search starts just past the last winner
    always_comb begin
        found    = 1'b0;
        grantIdx = lastGrant;
        for (int i = 1; i <= `FAB_NUM_NODES; i++) begin
            if (!found && rspValid[(int'(lastGrant) + i) % `FAB_NUM_NODES]) begin
                found    = 1'b1;
                grantIdx = IDX_W'((int'(lastGrant) + i) % `FAB_NUM_NODES);
            end
        end
    end

    assign grant  = found && (credits != '0);
    assign rspPop = `FAB_NUM_NODES'(grant) << grantIdx;

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            lastGrant <= '0;
            outValid  <= 1'b0;
            credits   <= CNT_W'(`FAB_OUT_CREDITS);
        end else begin
            outValid <= grant;
            credits  <= credits - CNT_W'(grant) + CNT_W'(outCredit);
            if (grant) begin
                lastGrant <= grantIdx;
            end
        end
    end

    always_ff @(posedge QClk) begin
        if (grant) begin
            outRsp <= rspData[grantIdx];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module memFabricTb -f build.f -o memFabricSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/memFabricSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

//--- verification/fabricModel.svh
`ifndef FABRIC_MODEL_SVH
`define FABRIC_MODEL_SVH

// ==================================================
// Reference state of every node
// ==================================================
logic [31:0]           modelMem [`FAB_NUM_NODES][`FAB_MEM_WORDS];
logic [31:0]           modelCr  [`FAB_NUM_NODES][`FAB_CR_COUNT];

// Expected fabric responses, oldest first, one queue per node
fabricPkg::fabricRsp_t expQ     [`FAB_NUM_NODES][$];

function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                           input logic [31:0] newWord,
                                           input logic [3:0]  byteEn);
    logic [31:0] result;
    result = oldWord;
    for (int b = 0; b < 4; b++) begin
        if (byteEn[b]) begin
            result[8*b +: 8] = newWord[8*b +: 8];
        end
    end
    return result;
endfunction

function automatic logic [31:0] modelRead(input int node, input fabricPkg::region_e region,
                                          input logic [7:0] offset);
    if (region == fabricPkg::REGION_CR) begin
        return modelCr[node][offset % `FAB_CR_COUNT];
    end
    return modelMem[node][offset];
endfunction

function automatic void modelWrite(input int node, input fabricPkg::region_e region,
                                   input logic [7:0] offset, input logic [3:0] byteEn,
                                   input logic [31:0] data);
    int idx;
    idx = offset % `FAB_CR_COUNT;
    if (region == fabricPkg::REGION_CR) begin
        modelCr[node][idx] = mergeBytes(modelCr[node][idx], data, byteEn);
    end else begin
        modelMem[node][offset] = mergeBytes(modelMem[node][offset], data, byteEn);
    end
endfunction

function automatic int pendingResponses();
    int total;
    total = 0;
    for (int n = 0; n < `FAB_NUM_NODES; n++) begin
        total += expQ[n].size();
    end
    return total;
endfunction

`endif

//--- verification/memFabricTb.sv
`timescale 1ns/100ps
`include "fabric_macros.svh"

module memFabricTb;

    localparam int RESET_CYCLES    = 16;
    localparam int CORE_OPS        = 8;
    localparam int BURST_LEN       = 12;
    localparam int STALL_CYCLES    = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STALL_CYCLES
                                   + 30 * (`FAB_NUM_NODES * (2 * CORE_OPS + 24) + BURST_LEN);

    logic                                      QClk;
    logic                                      arstN;
    logic                                      reqValid;
    fabricPkg::fabricReq_t                     req;
    logic                                      outCredit;
    fabricPkg::coreReq_t [`FAB_NUM_NODES-1:0]  coreReq;
    logic                                      reqCredit;
    logic                                      outValid;
    fabricPkg::fabricRsp_t                     outRsp;
    logic [`FAB_NUM_NODES-1:0][31:0]           coreRdData;
    fabricPkg::coreCr_t [`FAB_NUM_NODES-1:0]   crOut;

    `include "fabricModel.svh"

    integer      seed;
    int          reqCreditsHeld;
    int          owedOut;
    bit          returnCredits;
    logic [3:0]  nextTag;
    logic [31:0] coreExpNext [`FAB_NUM_NODES];
    logic [31:0] coreExpCur  [`FAB_NUM_NODES];
    int          outUsed;
    int          outReturned;

    memFabricTop uut (
        .QClk       (QClk),
        .arstN      (arstN),
        .reqValid   (reqValid),
        .req        (req),
        .outCredit  (outCredit),
        .coreReq    (coreReq),
        .reqCredit  (reqCredit),
        .outValid   (outValid),
        .outRsp     (outRsp),
        .coreRdData (coreRdData),
        .crOut      (crOut)
    );

    initial begin
        QClk = 1'b0;
        forever begin
            #5 QClk = ~QClk;
        end
    end

    // ==================================================
    // Failure reporting
    // ==================================================
    task stopWithFail(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task reportMismatch(input string msg);
        stopWithFail($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge QClk);
        stopWithFail("Watchdog expired before the tests finished");
    end

    // ==================================================
    // Checkers
    // ==================================================
    // Expected core data follows the read by one clock
    always @(posedge QClk) begin
        for (int i = 0; i < `FAB_NUM_NODES; i++) begin
            coreExpCur[i] = coreExpNext[i];
        end
        if (arstN) begin
            outReturned += int'(outCredit);
        end
    end

    always @(negedge QClk) begin
        fabricPkg::fabricRsp_t exp;
        if (!arstN) begin
            assert (!outValid && !reqCredit)
                else reportMismatch("outValid or reqCredit high during reset");
            for (int i = 0; i < `FAB_NUM_NODES; i++) begin
                assert (crOut[i] == '0)
                    else reportMismatch($sformatf("node %0d crOut not zero in reset", i));
            end
        end
        for (int i = 0; i < `FAB_NUM_NODES; i++) begin
            assert (coreRdData[i] == coreExpCur[i])
                else reportMismatch($sformatf("node %0d core read %h, expected %h",
                                              i, coreRdData[i], coreExpCur[i]));
        end
        if (outValid) begin
            outUsed++;
            assert (outUsed <= `FAB_OUT_CREDITS + outReturned)
                else stopWithFail("Collector sent a response without an output credit");
            if (expQ[outRsp.nodeId].size() == 0) begin
                stopWithFail($sformatf("Unexpected response from node %0d", outRsp.nodeId));
            end else begin
                exp = expQ[outRsp.nodeId].pop_front();
                assert (outRsp == exp)
                    else reportMismatch($sformatf("response %h, expected %h", outRsp, exp));
            end
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    // One cycle, all drives start from idle
    task tick();
        @(negedge QClk);
        if (reqCredit) begin
            reqCreditsHeld++;
        end
        if (outValid) begin
            owedOut++;
        end
        reqValid  = 1'b0;
        outCredit = returnCredits && (owedOut > 0);
        if (outCredit) begin
            owedOut--;
        end
        for (int i = 0; i < `FAB_NUM_NODES; i++) begin
            coreReq[i]     = '0;
            coreExpNext[i] = '0;
        end
    endtask

    task sendFabric(input fabricPkg::opcode_e op, input int node,
                    input fabricPkg::region_e region, input logic [7:0] offset,
                    input logic [31:0] data);
        fabricPkg::fabricReq_t r;
        fabricPkg::fabricRsp_t e;
        tick();
        while (reqCreditsHeld == 0) begin
            tick();
        end
        r.opcode      = op;
        r.addr.nodeId = 2'(node);
        r.addr.region = region;
        r.addr.offset = offset;
        r.data        = data;
        r.tag         = nextTag;
        req           = r;
        reqValid      = 1'b1;
        reqCreditsHeld--;
        nextTag++;
        if (op == fabricPkg::OP_WR) begin
            modelWrite(node, region, offset, 4'hF, data);
        end else begin
            e.nodeId = 2'(node);
            e.tag    = r.tag;
            e.data   = modelRead(node, region, offset);
            expQ[node].push_back(e);
        end
    endtask

    // Drives in the current cycle, the caller has ticked
    task driveCoreWrite(input int node, input fabricPkg::region_e region,
                        input logic [7:0] offset, input logic [3:0] byteEn,
                        input logic [31:0] data);
        coreReq[node].wrEn   = 1'b1;
        coreReq[node].region = region;
        coreReq[node].offset = offset;
        coreReq[node].byteEn = byteEn;
        coreReq[node].wrData = data;
        modelWrite(node, region, offset, byteEn, data);
    endtask

    task coreWrite(input int node, input fabricPkg::region_e region,
                   input logic [7:0] offset, input logic [3:0] byteEn,
                   input logic [31:0] data);
        tick();
        driveCoreWrite(node, region, offset, byteEn, data);
    endtask

    task coreRead(input int node, input fabricPkg::region_e region, input logic [7:0] offset);
        tick();
        coreReq[node].rdEn   = 1'b1;
        coreReq[node].region = region;
        coreReq[node].offset = offset;
        coreExpNext[node]    = modelRead(node, region, offset);
    endtask

    task waitIdle();
        tick();
        while (pendingResponses() != 0) begin
            tick();
        end
    endtask

    task checkCrOut();
        tick();
        for (int n = 0; n < `FAB_NUM_NODES; n++) begin
            for (int k = 0; k < `FAB_CR_COUNT; k++) begin
                assert (crOut[n][k] == modelCr[n][k])
                    else reportMismatch($sformatf("node %0d crOut[%0d] %h, expected %h",
                                                  n, k, crOut[n][k], modelCr[n][k]));
            end
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [7:0]  offs [CORE_OPS];
        logic [31:0] value;
        seed           = 32'haaed;
        arstN          = 1'b0;
        reqValid       = 1'b0;
        req            = '0;
        outCredit      = 1'b0;
        coreReq        = '0;
        reqCreditsHeld = `FAB_REQ_FIFO_DEPTH;
        owedOut        = 0;
        returnCredits  = 1'b1;
        nextTag        = '0;
        outUsed        = 0;
        outReturned    = 0;
        for (int n = 0; n < `FAB_NUM_NODES; n++) begin
            coreExpNext[n] = '0;
            coreExpCur[n]  = '0;
            for (int w = 0; w < `FAB_MEM_WORDS; w++) begin
                modelMem[n][w] = '0;
            end
            for (int k = 0; k < `FAB_CR_COUNT; k++) begin
                modelCr[n][k] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge QClk);
        @(negedge QClk);
        arstN = 1'b1;

        // Fresh state reads as zero
        for (int n = 0; n < `FAB_NUM_NODES; n++) begin
            coreRead(n, fabricPkg::REGION_DMEM, 8'(n * 9));
            coreRead(n, fabricPkg::REGION_CR, 8'(n));
        end
        checkCrOut();

        // Core writes with random lanes, then read back
        for (int n = 0; n < `FAB_NUM_NODES; n++) begin
            for (int k = 0; k < CORE_OPS; k++) begin
                offs[k] = 8'($random(seed));
                coreWrite(n, fabricPkg::REGION_DMEM, offs[k], 4'($random(seed)), $random(seed));
            end
            for (int k = 0; k < CORE_OPS; k++) begin
                coreRead(n, fabricPkg::REGION_DMEM, offs[k]);
            end
        end

        // Fabric writes then reads on every node
        for (int n = 0; n < `FAB_NUM_NODES; n++) begin
            for (int k = 0; k < 4; k++) begin
                sendFabric(fabricPkg::OP_WR, n, fabricPkg::REGION_DMEM, 8'(100 + k),
                           $random(seed));
            end
            for (int k = 0; k < 4; k++) begin
                sendFabric(fabricPkg::OP_RD, n, fabricPkg::REGION_DMEM, 8'(100 + k), '0);
            end
        end
        waitIdle();

        // Core to fabric, fabric to core, and a same-cycle collision
        for (int n = 0; n < `FAB_NUM_NODES; n++) begin
            coreWrite(n, fabricPkg::REGION_DMEM, 8'd200, 4'hF, $random(seed));
            sendFabric(fabricPkg::OP_RD, n, fabricPkg::REGION_DMEM, 8'd200, '0);
            sendFabric(fabricPkg::OP_WR, n, fabricPkg::REGION_DMEM, 8'd201, $random(seed));
            sendFabric(fabricPkg::OP_WR, n, fabricPkg::REGION_DMEM, 8'd202, $random(seed));
            // Core write goes out with the fabric write to word 202
            tick();
            while (!(uut.nodeReqValid[n] && uut.nodeReq.addr.offset == 8'd202)) begin
                tick();
            end
            value = $random(seed);
            driveCoreWrite(n, fabricPkg::REGION_DMEM, 8'd202, 4'($random(seed)), value);
            sendFabric(fabricPkg::OP_RD, n, fabricPkg::REGION_DMEM, 8'd202, '0);
            waitIdle();
            coreRead(n, fabricPkg::REGION_DMEM, 8'd201);
            coreRead(n, fabricPkg::REGION_DMEM, 8'd202);
        end

        // CR region from both sides
        for (int n = 0; n < `FAB_NUM_NODES; n++) begin
            for (int k = 0; k < `FAB_CR_COUNT; k++) begin
                coreWrite(n, fabricPkg::REGION_CR, 8'(k), 4'($random(seed)), $random(seed));
            end
            sendFabric(fabricPkg::OP_WR, n, fabricPkg::REGION_CR, 8'd2, $random(seed));
            for (int k = 0; k < `FAB_CR_COUNT; k++) begin
                sendFabric(fabricPkg::OP_RD, n, fabricPkg::REGION_CR, 8'(k), '0);
            end
            waitIdle();
            for (int k = 0; k < `FAB_CR_COUNT; k++) begin
                coreRead(n, fabricPkg::REGION_CR, 8'(k));
                coreRead(n, fabricPkg::REGION_DMEM, 8'(k));
            end
        end
        checkCrOut();

        // Burst of reads with output credits held back
        returnCredits = 1'b0;
        for (int k = 0; k < BURST_LEN; k++) begin
            sendFabric(fabricPkg::OP_RD, k % `FAB_NUM_NODES, fabricPkg::REGION_DMEM,
                       8'(100 + k / `FAB_NUM_NODES), '0);
        end
        repeat (STALL_CYCLES) begin
            tick();
        end
        returnCredits = 1'b1;
        waitIdle();
        repeat (4) begin
            tick();
        end

        if (reqCreditsHeld != `FAB_REQ_FIFO_DEPTH) begin
            reportMismatch($sformatf("request credits held %0d, expected %0d",
                                     reqCreditsHeld, `FAB_REQ_FIFO_DEPTH));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule
